// File: common/daq_pkg.sv
`default_nettype none

package daq_pkg;

  //////////////////////////////
  // clocking and widths
  localparam int unsigned CLK_FREQ   = 20_000_000; // xtal, Hz
  localparam int unsigned REG_W      = 32;
  localparam int unsigned CNT_W      = 24;         // clk counters
  localparam int unsigned SEQ_MAX    = 4;          // seq words held
  localparam int unsigned SEQ_IDX_W  = 3;
  localparam int unsigned SEQ_WORD_W = 6;          // [3:0] azmux, [5:4] pc_sw

  // refmux test timing in clk cycles
  localparam int unsigned REFMUX_CNT_RESET = CLK_FREQ / 1_000_000 * 500; // 500us
  localparam int unsigned REFMUX_CNT_FIX   = CLK_FREQ / 1_000_000 * 150; // 150us

  localparam logic [7:0] MAGIC = 8'hAA;

  //////////////////////////////
  // register map, 7 bit address
  localparam logic [6:0] REG_SPI_MUX      = 7'd1;
  localparam logic [6:0] REG_4094         = 7'd2;
  localparam logic [6:0] REG_MODE         = 7'd3;
  localparam logic [6:0] REG_DIRECT       = 7'd4;
  localparam logic [6:0] REG_STATUS       = 7'd5;  // read only
  localparam logic [6:0] REG_SA_PRECHARGE = 7'd6;
  localparam logic [6:0] REG_SA_SEQ_N     = 7'd7;
  localparam logic [6:0] REG_SA_SEQ0      = 7'd8;
  localparam logic [6:0] REG_SA_SEQ1      = 7'd9;
  localparam logic [6:0] REG_SA_SEQ2      = 7'd10;
  localparam logic [6:0] REG_SA_SEQ3      = 7'd11;
  localparam logic [6:0] REG_SA_TRIG      = 7'd12;
  localparam logic [6:0] REG_ADC_APERTURE = 7'd13;

  // alternate function modes
  localparam logic [2:0] MODE_DIRECT      = 3'd0;
  localparam logic [2:0] MODE_REFMUX_TEST = 3'd5;
  localparam logic [2:0] MODE_SA_MOCK     = 3'd6;

  // spi peripheral select, one hot
  localparam logic [3:0] SPI_TGT_NONE     = 4'b0000;
  localparam logic [3:0] SPI_TGT_4094     = 4'b0001;
  localparam logic [3:0] SPI_TGT_DAC      = 4'b0010;
  localparam logic [3:0] SPI_TGT_ISO_DAC  = 4'b0100;
  localparam logic [3:0] SPI_TGT_ISO_DAC2 = 4'b1000;

  // pin set, lsb first is leds. same layout as REG_DIRECT[23:0]
  typedef struct packed {
    logic       spi_interrupt; // 23
    logic       cmpr_latch;    // 22
    logic [3:0] adc_refmux;    // 18+4  pos,neg,sigmux,reset
    logic [3:0] azmux;         // 14+4
    logic [1:0] pc_sw;         // 12+2
    logic [7:0] monitor;       // 4+8
    logic [3:0] leds;          // 0+4
  } pins_t;

  typedef struct packed {
    logic [SEQ_IDX_W-1:0]                  seq_n;
    logic [SEQ_MAX-1:0][SEQ_WORD_W-1:0]    seq;
    logic [CNT_W-1:0]                      precharge;
  } sa_cfg_t;

  typedef struct packed {
    logic [3:0]       spi_mux;
    logic             oe_4094;
    logic [2:0]       mode;
    pins_t            direct;
    sa_cfg_t          sa_cfg;
    logic             sa_arm;
    logic [CNT_W-1:0] aperture;
  } ctrl_regs_t;

endpackage

`default_nettype wire

// File: design/spi_regs.sv
`timescale 1ns/10ps
`default_nettype none

module spi_regs (
  input  logic                          sck_i,
  input  logic                          ss_n_i,
  input  logic                          sdi_i,
  input  logic                          rst_n_i,
  input  logic [3:0]                    hw_flags_i,
  input  logic [daq_pkg::SEQ_IDX_W-1:0] sample_idx_last_i,
  output logic                          sdo_o,
  output daq_pkg::ctrl_regs_t           regs_o
);
  import daq_pkg::*;

  logic [5:0]       bit_cnt_q;  // rising edges seen in frame
  logic [REG_W-1:0] shift_q;    // mosi shifter
  logic [7:0]       cmd_q;      // wr flag + addr
  logic [REG_W-1:0] rd_q;       // miso shifter
  logic [REG_W-1:0] rd_data;
  logic [REG_W-1:0] wr_data;
  logic [REG_W-1:0] status;
  logic             wr_en;
  ctrl_regs_t       regs_q;

  //////////////////////////////
  // frame, cleared while ss_n high
  always_ff @(posedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      bit_cnt_q <= '0;
    end else if (!rst_n_i) begin
      bit_cnt_q <= '0;
    end else if (bit_cnt_q != 6'd40) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;  // saturate, extra clocks ignored
    end
  end

  always_ff @(posedge sck_i) begin
    shift_q <= {shift_q[REG_W-2:0], sdi_i};
    if (bit_cnt_q == 6'd7)
      cmd_q <= {shift_q[6:0], sdi_i};  // 8th edge completes command
  end

  assign wr_data = {shift_q[REG_W-2:0], sdi_i};
  assign wr_en   = !ss_n_i && (bit_cnt_q == 6'd39) && cmd_q[7];  // 40th edge

  //////////////////////////////
  // writable registers
  always_ff @(posedge sck_i) begin
    if (!rst_n_i) begin
      regs_q <= '0;
    end else if (wr_en) begin
      case (cmd_q[6:0])
        REG_SPI_MUX:      regs_q.spi_mux          <= wr_data[3:0];
        REG_4094:         regs_q.oe_4094          <= wr_data[0];  // lo at power up
        REG_MODE:         regs_q.mode             <= wr_data[2:0];
        REG_DIRECT:       regs_q.direct           <= pins_t'(wr_data[$bits(pins_t)-1:0]);
        REG_SA_PRECHARGE: regs_q.sa_cfg.precharge <= wr_data[CNT_W-1:0];
        REG_SA_SEQ_N:     regs_q.sa_cfg.seq_n     <= wr_data[SEQ_IDX_W-1:0];
        REG_SA_SEQ0:      regs_q.sa_cfg.seq[0]    <= wr_data[SEQ_WORD_W-1:0];
        REG_SA_SEQ1:      regs_q.sa_cfg.seq[1]    <= wr_data[SEQ_WORD_W-1:0];
        REG_SA_SEQ2:      regs_q.sa_cfg.seq[2]    <= wr_data[SEQ_WORD_W-1:0];
        REG_SA_SEQ3:      regs_q.sa_cfg.seq[3]    <= wr_data[SEQ_WORD_W-1:0];
        REG_SA_TRIG:      regs_q.sa_arm           <= wr_data[0];
        REG_ADC_APERTURE: regs_q.aperture         <= wr_data[CNT_W-1:0];
        default: ;  // status and unmapped, dropped
      endcase
    end
  end

  assign regs_o = regs_q;

  // status, lsb up
  assign status = {
    8'h00,
    1'b0, sample_idx_last_i,  // 20+3
    1'b0, regs_q.sa_cfg.seq_n, // 16+3
    hw_flags_i,               // 12+4
    regs_q.spi_mux,           // 8+4
    MAGIC                     // 0+8
  };

  //////////////////////////////
  // readback
  always_comb begin
    case (cmd_q[6:0])
      REG_SPI_MUX:      rd_data = REG_W'(regs_q.spi_mux);
      REG_4094:         rd_data = REG_W'(regs_q.oe_4094);
      REG_MODE:         rd_data = REG_W'(regs_q.mode);
      REG_DIRECT:       rd_data = REG_W'(regs_q.direct);
      REG_STATUS:       rd_data = status;
      REG_SA_PRECHARGE: rd_data = REG_W'(regs_q.sa_cfg.precharge);
      REG_SA_SEQ_N:     rd_data = REG_W'(regs_q.sa_cfg.seq_n);
      REG_SA_SEQ0:      rd_data = REG_W'(regs_q.sa_cfg.seq[0]);
      REG_SA_SEQ1:      rd_data = REG_W'(regs_q.sa_cfg.seq[1]);
      REG_SA_SEQ2:      rd_data = REG_W'(regs_q.sa_cfg.seq[2]);
      REG_SA_SEQ3:      rd_data = REG_W'(regs_q.sa_cfg.seq[3]);
      REG_SA_TRIG:      rd_data = REG_W'(regs_q.sa_arm);
      REG_ADC_APERTURE: rd_data = REG_W'(regs_q.aperture);
      default:          rd_data = '0;
    endcase
  end

  // load on the falling edge after the command, msb first
  always_ff @(negedge sck_i) begin
    if (bit_cnt_q == 6'd8)
      rd_q <= rd_data;
    else
      rd_q <= {rd_q[REG_W-2:0], 1'b0};
  end

  assign sdo_o = rd_q[REG_W-1];

endmodule

`default_nettype wire

// File: acq/acq_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module acq_sequencer (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          arm_i,
  input  daq_pkg::sa_cfg_t              cfg_i,
  input  logic                          measure_valid_i,
  output logic                          adc_reset_n_o,
  output logic [daq_pkg::SEQ_IDX_W-1:0] sample_idx_last_o,
  output daq_pkg::pins_t                pins_o
);
  import daq_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_PRECHARGE,  // word applied, adc held in reset
    S_MEASURE     // adc running, wait for valid
  } state_t;

  state_t                state_q;
  logic [CNT_W-1:0]      cnt_q;
  logic [SEQ_IDX_W-1:0]  idx_q;
  logic [SEQ_IDX_W-1:0]  idx_next;
  logic [SEQ_IDX_W-1:0]  idx_last_q;
  logic                  led_q;
  logic [SEQ_WORD_W-1:0] word;

  assign word = cfg_i.seq[idx_q[$clog2(SEQ_MAX)-1:0]];

  // wrap after seq_n-1
  assign idx_next = (idx_q + 1'b1 >= cfg_i.seq_n) ? '0 : idx_q + 1'b1;

  //////////////////////////////
  // sample sequencing
  always_ff @(posedge clk) begin
    if (!rst_n_i || !arm_i) begin
      state_q    <= S_IDLE;
      cnt_q      <= '0;
      idx_q      <= '0;
      idx_last_q <= '0;
      led_q      <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          state_q <= S_PRECHARGE;  // armed, start at seq0
          cnt_q   <= '0;
        end
        S_PRECHARGE: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q + 1'b1 >= cfg_i.precharge)
            state_q <= S_MEASURE;  // precharge count done
        end
        S_MEASURE: begin
          if (measure_valid_i) begin
            idx_last_q <= idx_q;    // completed sample
            idx_q      <= idx_next;
            led_q      <= !led_q;
            cnt_q      <= '0;
            state_q    <= S_PRECHARGE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign adc_reset_n_o     = (state_q == S_MEASURE);
  assign sample_idx_last_o = idx_last_q;

  // switches only while a sequence runs
  always_comb begin
    pins_o = '0;
    if (state_q != S_IDLE) begin
      pins_o.azmux = word[3:0];
      pins_o.pc_sw = word[5:4];
    end
    pins_o.leds    = {3'b000, led_q};
    pins_o.monitor = {
      2'b00,
      measure_valid_i,         // 5
      idx_q,                   // 4:2
      state_q == S_MEASURE,    // 1
      state_q == S_PRECHARGE   // 0
    };
  end

endmodule

`default_nettype wire

// File: acq/adc_mock.sv
`timescale 1ns/10ps
`default_nettype none

module adc_mock (
  input  logic                      clk,
  input  logic                      adc_reset_n_i,
  input  logic [daq_pkg::CNT_W-1:0] aperture_i,
  output logic                      measure_valid_o
);
  import daq_pkg::*;

  logic [CNT_W-1:0] cnt_q;
  logic             done_q;   // one valid per reset release
  logic             valid_q;

  // aperture count in place of the modulator
  always_ff @(posedge clk) begin
    valid_q <= 1'b0;  // single cycle strobe
    if (!adc_reset_n_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (!done_q) begin
      if (cnt_q == aperture_i) begin
        valid_q <= 1'b1;  // aperture+1 cycles after release
        done_q  <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign measure_valid_o = valid_q;

endmodule

`default_nettype wire

// File: design/refmux_test.sv
`timescale 1ns/10ps
`default_nettype none

module refmux_test (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       cmpr_i,
  output logic [3:0] refmux_o,   // pos, neg, sigmux, reset from bit 0
  output logic [7:0] monitor_o
);
  import daq_pkg::*;

  logic [CNT_W-1:0] cnt_q;
  logic             in_reset_q;  // integrator reset phase
  logic             pos_q;
  logic             neg_q;
  logic             strobe_q;    // period start
  logic             period_end;

  // last cycle of reset phase or of a fix period
  assign period_end = in_reset_q ? (cnt_q == CNT_W'(REFMUX_CNT_RESET - 1))
                                 : (cnt_q == CNT_W'(REFMUX_CNT_FIX - 1));

  //////////////////////////////
  // charge balance, fixed period
  always_ff @(posedge clk) begin
    strobe_q <= 1'b0;
    if (!rst_n_i) begin
      cnt_q      <= '0;
      in_reset_q <= 1'b1;
      pos_q      <= 1'b0;
      neg_q      <= 1'b0;
    end else if (period_end) begin
      cnt_q      <= '0;
      in_reset_q <= 1'b0;
      pos_q      <= cmpr_i;   // steer current against the comparator
      neg_q      <= !cmpr_i;
      strobe_q   <= 1'b1;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign refmux_o = {
    in_reset_q,  // reset
    1'b0,        // sigmux, input left off
    neg_q,
    pos_q
  };

  assign monitor_o = {3'b000, neg_q, pos_q, in_reset_q, strobe_q, cmpr_i};

endmodule

`default_nettype wire

// File: design/mode_select.sv
`timescale 1ns/10ps
`default_nettype none

module mode_select (
  input  logic [2:0]     mode_i,
  input  daq_pkg::pins_t direct_i,
  input  daq_pkg::pins_t sa_pins_i,
  input  logic [3:0]     refmux_i,
  input  logic [7:0]     refmux_mon_i,
  input  logic [3:0]     spi_mux_i,
  input  logic           sck_i,
  input  logic           sdi_i,
  input  logic           cs2_i,
  output daq_pkg::pins_t pins_o,
  output logic           spi_clk_o,
  output logic           spi_mosi_o,
  output logic           strobe_4094_o,
  output logic           dac_ss_o,
  output logic           iso_dac_cs_o,
  output logic           iso_dac_cs2_o
);
  import daq_pkg::*;

  logic spi_park;

  //////////////////////////////
  // alternate function mux
  always_comb begin
    pins_o = '0;  // unassigned modes all low
    case (mode_i)
      MODE_DIRECT:      pins_o = direct_i;
      MODE_REFMUX_TEST: begin
        pins_o.adc_refmux = refmux_i;
        pins_o.monitor    = refmux_mon_i;
      end
      MODE_SA_MOCK:     pins_o = sa_pins_i;
      default: ;
    endcase
  end

  //////////////////////////////
  // spi peripheral routing
  assign spi_park = (spi_mux_i == SPI_TGT_NONE);

  assign spi_clk_o  = spi_park ? 1'b1 : sck_i;  // park hi
  assign spi_mosi_o = spi_park ? 1'b1 : sdi_i;

  assign strobe_4094_o = (spi_mux_i == SPI_TGT_4094)     ? !cs2_i : 1'b0;  // active hi
  assign dac_ss_o      = (spi_mux_i == SPI_TGT_DAC)      ? cs2_i  : 1'b1;  // active lo
  assign iso_dac_cs_o  = (spi_mux_i == SPI_TGT_ISO_DAC)  ? cs2_i  : 1'b1;
  assign iso_dac_cs2_o = (spi_mux_i == SPI_TGT_ISO_DAC2) ? cs2_i  : 1'b1;

endmodule

`default_nettype wire

// File: design/daq_top.sv
`timescale 1ns/10ps
`default_nettype none

module daq_top (
  input  logic       clk,
  input  logic       rst_n_i,

  // host spi
  input  logic       sck_i,
  input  logic       ss_n_i,
  input  logic       sdi_i,
  input  logic       spi_cs2_i,
  output logic       sdo_o,

  input  logic [3:0] hw_flags_i,
  input  logic       adc_cmpr_out_i,
  input  logic       u1008_4094_data_i,  // 4094 serial out, not read back

  // pins
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic [3:0] adc_refmux_o,
  output logic       adc_cmpr_latch_o,
  output logic       spi_interrupt_o,

  // peripheral spi
  output logic       spi_clk_o,
  output logic       spi_mosi_o,
  output logic       spi_4094_strobe_o,
  output logic       spi_dac_ss_o,
  output logic       spi_iso_dac_cs_o,
  output logic       spi_iso_dac_cs2_o,
  output logic       oe_4094_o
);
  import daq_pkg::*;

  ctrl_regs_t           regs;
  pins_t                sa_pins;
  pins_t                pins;
  logic [SEQ_IDX_W-1:0] sa_idx_last;
  logic                 adc_reset_n;
  logic                 measure_valid;
  logic [3:0]           refmux;
  logic [7:0]           refmux_mon;
  logic                 cmpr_p;
  logic                 refmux_rst_n;

  assign cmpr_p = !adc_cmpr_out_i;  // pcb comparator output is inverted

  // refmux test only runs while its mode is selected
  assign refmux_rst_n = rst_n_i && (regs.mode == MODE_REFMUX_TEST);

  //////////////////////////////
  // host registers, sck domain
  spi_regs u_spi_regs (
    .sck_i             (sck_i),
    .ss_n_i            (ss_n_i),
    .sdi_i             (sdi_i),
    .rst_n_i           (rst_n_i),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sa_idx_last),
    .sdo_o             (sdo_o),
    .regs_o            (regs)
  );

  //////////////////////////////
  // acquisition, mocked adc
  acq_sequencer u_acq_sequencer (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .arm_i             (regs.sa_arm),
    .cfg_i             (regs.sa_cfg),
    .measure_valid_i   (measure_valid),
    .adc_reset_n_o     (adc_reset_n),
    .sample_idx_last_o (sa_idx_last),
    .pins_o            (sa_pins)
  );

  adc_mock u_adc_mock (
    .clk             (clk),
    .adc_reset_n_i   (adc_reset_n),
    .aperture_i      (regs.aperture),
    .measure_valid_o (measure_valid)
  );

  refmux_test u_refmux_test (
    .clk       (clk),
    .rst_n_i   (refmux_rst_n),
    .cmpr_i    (cmpr_p),
    .refmux_o  (refmux),
    .monitor_o (refmux_mon)
  );

  //////////////////////////////
  // pin and spi muxing
  mode_select u_mode_select (
    .mode_i        (regs.mode),
    .direct_i      (regs.direct),
    .sa_pins_i     (sa_pins),
    .refmux_i      (refmux),
    .refmux_mon_i  (refmux_mon),
    .spi_mux_i     (regs.spi_mux),
    .sck_i         (sck_i),
    .sdi_i         (sdi_i),
    .cs2_i         (spi_cs2_i),
    .pins_o        (pins),
    .spi_clk_o     (spi_clk_o),
    .spi_mosi_o    (spi_mosi_o),
    .strobe_4094_o (spi_4094_strobe_o),
    .dac_ss_o      (spi_dac_ss_o),
    .iso_dac_cs_o  (spi_iso_dac_cs_o),
    .iso_dac_cs2_o (spi_iso_dac_cs2_o)
  );

  assign leds_o           = pins.leds;
  assign monitor_o        = pins.monitor;
  assign pc_sw_o          = pins.pc_sw;
  assign azmux_o          = pins.azmux;
  assign adc_refmux_o     = pins.adc_refmux;
  assign adc_cmpr_latch_o = pins.cmpr_latch;
  assign spi_interrupt_o  = pins.spi_interrupt;

  assign oe_4094_o = regs.oe_4094;  // outputs off until host enables

endmodule

`default_nettype wire

// File: test/tb_spi_tasks.svh
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// xorshift32, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// one 40 bit frame, sck at half clk rate
task automatic spi_frame(input logic wr, input logic [6:0] addr,
                         input logic [31:0] wdata, output logic [31:0] rdata);
  logic [39:0] tx;
  int          i;
  tx    = {wr, addr, wdata};
  rdata = '0;
  @(posedge clk);
  #2;
  ss_n = 1'b0;
  for (i = 39; i >= 0; i--) begin
    @(posedge clk);
    #2;
    sck = 1'b0;   // sdo moves on this fall
    sdi = tx[i];
    @(posedge clk);
    if (i < 32)
      rdata = {rdata[30:0], sdo};  // settled since the fall
    #2;
    sck = 1'b1;   // dut samples sdi
  end
  @(posedge clk);
  #2;
  sck = 1'b0;
  @(posedge clk);
  #2;
  ss_n = 1'b1;
  sdi  = 1'b0;
  @(posedge clk);
endtask

task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
  logic [31:0] unused_rd;
  spi_frame(1'b1, addr, data, unused_rd);
endtask

task automatic read_reg(input logic [6:0] addr, output logic [31:0] data);
  spi_frame(1'b0, addr, 32'h0, data);
endtask

`endif

// File: test/tb_daq.sv
`timescale 1ns/10ps
`default_nettype none

module tb_daq;
  import daq_pkg::*;

  localparam int TIMEOUT_CYCLES = 120_000;  // refmux phases dominate
  localparam int SA_SEQ_N       = 3;
  localparam int SA_PRECHARGE   = 30;
  localparam int SA_APERTURE    = 70;       // sample ~103 cycles outlasts a frame
  localparam int PH_NONE = 0, PH_DIRECT = 1, PH_LOW = 2, PH_ROUTE = 3, PH_SA = 4,
                 PH_REFMUX = 5;

  logic clk, rst_n, sck, ss_n, sdi, sdo, spi_cs2, cmpr_out, data_4094;
  logic [3:0] hw_flags;
  logic [3:0] leds, azmux, adc_refmux;
  logic [7:0] monitor;
  logic [1:0] pc_sw;
  logic       cmpr_latch, spi_interrupt, oe_4094;
  logic       spi_clk, spi_mosi, strobe_4094, dac_ss, iso_dac_cs, iso_dac_cs2;
  pins_t      pins_seen;

  int          reg_errs, pin_errs, route_errs, seq_errs, refmux_errs;
  int          cycle_cnt = 0;
  int          phase;
  logic [31:0] rng;
  pins_t       exp_direct;
  logic [3:0]  exp_mux;
  logic        exp_oe;
  logic [5:0]  words [4];
  logic [3:0]  targets [5] = '{SPI_TGT_NONE, SPI_TGT_4094, SPI_TGT_DAC,
                               SPI_TGT_ISO_DAC, SPI_TGT_ISO_DAC2};

  // sequence monitor state
  logic [5:0]  prev_word;
  int          exp_idx, n_words, pre_cnt;
  logic [2:0]  cur_idx, last_done;
  logic        in_pre;

  `include "tb_spi_tasks.svh"

  daq_top DUT (
    .clk (clk), .rst_n_i (rst_n),
    .sck_i (sck), .ss_n_i (ss_n), .sdi_i (sdi), .spi_cs2_i (spi_cs2), .sdo_o (sdo),
    .hw_flags_i (hw_flags), .adc_cmpr_out_i (cmpr_out), .u1008_4094_data_i (data_4094),
    .leds_o (leds), .monitor_o (monitor), .pc_sw_o (pc_sw), .azmux_o (azmux),
    .adc_refmux_o (adc_refmux), .adc_cmpr_latch_o (cmpr_latch),
    .spi_interrupt_o (spi_interrupt),
    .spi_clk_o (spi_clk), .spi_mosi_o (spi_mosi), .spi_4094_strobe_o (strobe_4094),
    .spi_dac_ss_o (dac_ss), .spi_iso_dac_cs_o (iso_dac_cs),
    .spi_iso_dac_cs2_o (iso_dac_cs2), .oe_4094_o (oe_4094)
  );

  assign pins_seen = {spi_interrupt, cmpr_latch, adc_refmux, azmux, pc_sw, monitor, leds};

  always #10 clk = ~clk;  // 20 ns

  function automatic int error_total();
    return reg_errs + pin_errs + route_errs + seq_errs + refmux_errs;
  endfunction

  task automatic report_counts();
    $display("summary: reg %0d, pin %0d, route %0d, seq %0d, refmux %0d errors",
             reg_errs, pin_errs, route_errs, seq_errs, refmux_errs);
  endtask

  task automatic check_reg(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got == exp) else begin
      reg_errs++;
      $display("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////
  // pin and routing checks
  direct_pins: assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_DIRECT |-> pins_seen == exp_direct)
    else begin
      pin_errs++;
      $display("FAILED at %0t: direct pins %h, expected %h", $time, pins_seen, exp_direct);
    end

  idle_pins: assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_LOW |-> pins_seen == '0)
    else begin
      pin_errs++;
      $display("FAILED at %0t: unassigned mode pins %h, expected 0", $time, pins_seen);
    end

  cs_routing: assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_ROUTE |->
      strobe_4094 == ((exp_mux == SPI_TGT_4094) ? !spi_cs2 : 1'b0) &&
      dac_ss == ((exp_mux == SPI_TGT_DAC) ? spi_cs2 : 1'b1) &&
      iso_dac_cs == ((exp_mux == SPI_TGT_ISO_DAC) ? spi_cs2 : 1'b1) &&
      iso_dac_cs2 == ((exp_mux == SPI_TGT_ISO_DAC2) ? spi_cs2 : 1'b1) &&
      oe_4094 == exp_oe)
    else begin
      route_errs++;
      $display("FAILED at %0t: routing mux %h cs2 %b gives %b%b%b%b oe %b", $time,
               exp_mux, spi_cs2, strobe_4094, dac_ss, iso_dac_cs, iso_dac_cs2, oe_4094);
    end

  clk_mosi_routing: assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_ROUTE |->
      (exp_mux == SPI_TGT_NONE) ? (spi_clk && spi_mosi) : (spi_clk == sck && spi_mosi == sdi))
    else begin
      route_errs++;
      $display("FAILED at %0t: spi clk/mosi %b%b with mux %h", $time, spi_clk, spi_mosi,
               exp_mux);
    end

  refmux_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_REFMUX |-> $onehot(adc_refmux[1:0]) && adc_refmux[3:2] == 2'b00)
    else begin
      refmux_errs++;
      $display("FAILED at %0t: refmux %b, expected one of pos/neg", $time, adc_refmux);
    end

  ////////////////////////////////
  // sequence order and precharge length
  always @(negedge clk) begin : seq_monitor
    logic [5:0] w;
    if (phase == PH_SA) begin
      w = {pc_sw, azmux};
      if (w != prev_word) begin
        assert (w == words[exp_idx]) else begin
          seq_errs++;
          $display("FAILED at %0t: word %h, expected seq%0d %h", $time, w, exp_idx,
                   words[exp_idx]);
        end
        assert (leds[0] == n_words[0]) else begin
          seq_errs++;
          $display("FAILED at %0t: led %b after %0d samples", $time, leds[0], n_words);
        end
        if (n_words > 0)
          last_done = cur_idx;  // previous sample finished
        cur_idx = 3'(exp_idx);
        exp_idx = (exp_idx + 1) % SA_SEQ_N;
        n_words++;
        pre_cnt = 1;
        in_pre  = 1'b1;
      end else if (in_pre) begin
        if (!monitor[1]) begin
          pre_cnt++;  // adc still held in reset
        end else begin
          assert (pre_cnt == SA_PRECHARGE) else begin
            seq_errs++;
            $display("FAILED at %0t: adc reset low %0d cycles, expected %0d", $time,
                     pre_cnt, SA_PRECHARGE);
          end
          in_pre = 1'b0;
        end
      end
      prev_word = w;
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      report_counts();
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////
  // stimulus
  initial begin : stimulus
    logic [31:0] rd;
    logic [31:0] val;
    logic [2:0]  s0, s1, v;
    int          k;
    clk         = 1'b0;
    rst_n       = 1'b0;
    sck         = 1'b0;
    ss_n        = 1'b1;
    sdi         = 1'b0;
    spi_cs2     = 1'b1;
    cmpr_out    = 1'b0;  // cmpr held low
    data_4094   = 1'b0;
    reg_errs    = 0;
    pin_errs    = 0;
    route_errs  = 0;
    seq_errs    = 0;
    refmux_errs = 0;
    phase       = PH_NONE;
    exp_mux     = '0;
    exp_oe      = 1'b0;
    exp_direct  = '0;
    prev_word   = '0;
    exp_idx     = 0;
    n_words     = 0;
    pre_cnt     = 0;
    in_pre      = 1'b0;
    cur_idx     = '0;
    last_done   = '0;
    rng = 32'h5957;
    rng = xorshift32(rng);
    hw_flags = rng[3:0];

    // reset with 8 idle sck edges for the spi side
    repeat (4) begin
      @(posedge clk);
      #2;
      sck = 1'b1;
      #10;
      sck = 1'b0;
    end
    @(posedge clk);
    #2;
    rst_n = 1'b1;

    // register access
    rng = xorshift32(rng);
    exp_direct = pins_t'(rng[23:0]);
    write_reg(REG_DIRECT, rng);
    read_reg(REG_DIRECT, rd);
    check_reg("direct", rd, {8'h00, exp_direct});
    rng = xorshift32(rng);
    val = rng;
    write_reg(REG_SA_SEQ0, val);
    read_reg(REG_SA_SEQ0, rd);
    check_reg("seq0", rd, {26'h0, val[5:0]});
    read_reg(REG_STATUS, rd);
    check_reg("status magic", {24'h0, rd[7:0]}, 32'h0000_00AA);
    check_reg("status hw_flags", {28'h0, rd[15:12]}, {28'h0, hw_flags});

    // direct mode then unassigned modes
    phase = PH_DIRECT;
    repeat (10) @(posedge clk);
    #2;
    phase = PH_NONE;
    for (k = 1; k < 8; k++) begin
      if (k != 5 && k != 6) begin
        write_reg(REG_MODE, k);
        phase = PH_LOW;
        repeat (5) @(posedge clk);
        #2;
        phase = PH_NONE;
      end
    end

    // spi routing per target
    for (k = 0; k < 5; k++) begin
      write_reg(REG_SPI_MUX, {28'h0, targets[k]});
      exp_mux = targets[k];
      phase   = PH_ROUTE;
      repeat (2) begin
        @(posedge clk);
        #2;
        spi_cs2 = 1'b0;
        sdi     = 1'b1;  // mosi and sck opposite so a swap shows
        repeat (3) @(posedge clk);
        #2;
        spi_cs2 = 1'b1;
        sdi     = 1'b0;
        sck     = 1'b1;  // ignored by spi_regs while ss_n is high
        repeat (3) @(posedge clk);
        #2;
        sck = 1'b0;
      end
      phase = PH_NONE;
    end
    write_reg(REG_SPI_MUX, 32'h0);
    exp_mux = SPI_TGT_NONE;
    for (k = 1; k >= 0; k--) begin
      write_reg(REG_4094, k);
      exp_oe = k[0];
      phase  = PH_ROUTE;
      repeat (4) @(posedge clk);
      #2;
      phase = PH_NONE;
    end

    // mock acquisition with distinct nonzero words
    for (k = 0; k < 4; k++) begin
      rng = xorshift32(rng);
      words[k] = {rng[5:2], 2'(k + 1)};
      write_reg(7'(REG_SA_SEQ0 + k), {26'h0, words[k]});
    end
    write_reg(REG_SA_SEQ_N, SA_SEQ_N);
    write_reg(REG_SA_PRECHARGE, SA_PRECHARGE);
    write_reg(REG_ADC_APERTURE, SA_APERTURE);
    write_reg(REG_MODE, {29'h0, MODE_SA_MOCK});
    phase = PH_SA;
    write_reg(REG_SA_TRIG, 32'h1);
    while (n_words < 8) begin
      s0 = last_done;
      read_reg(REG_STATUS, rd);
      s1 = last_done;
      v  = rd[22:20];
      assert (v < SA_SEQ_N && (v == s0 || v == s1)) else begin
        seq_errs++;
        $display("FAILED at %0t: status index %0d, expected %0d or %0d", $time, v, s0, s1);
      end
      check_reg("status seq_n", {29'h0, rd[18:16]}, SA_SEQ_N);
    end
    phase = PH_NONE;
    write_reg(REG_SA_TRIG, 32'h0);

    // refmux test waits out the reset phase
    write_reg(REG_MODE, {29'h0, MODE_REFMUX_TEST});
    while (adc_refmux[3] !== 1'b0)
      @(posedge clk);
    #2;
    phase = PH_REFMUX;
    repeat (2 * REFMUX_CNT_FIX) @(posedge clk);
    #2;
    assert (adc_refmux[0] == 1'b1) else begin
      refmux_errs++;
      $display("FAILED at %0t: refmux pos %b after two periods, expected 1", $time,
               adc_refmux[0]);
    end
    phase = PH_NONE;

    report_counts();
    if (error_total() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: daq_ctrl.f
+incdir+test
common/daq_pkg.sv
design/spi_regs.sv
acq/acq_sequencer.sv
acq/adc_mock.sv
design/refmux_test.sv
design/mode_select.sv
design/daq_top.sv
test/tb_daq.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_daq \
  -f daq_ctrl.f

out="$(./obj_dir/Vtb_daq)"
echo "$out"

if grep -q "^No errors$" <<< "$out"; then
  exit 0
else
  exit 1
fi
